// File: cpu.f
+incdir+design
design/cpu_pkg.sv
design/stage_counter.sv
design/cpu_control.sv
design/alu.sv
design/register_file.sv
design/main_memory.sv
design/cpu_top.sv
tb/cpu_tb.sv

// File: Makefile
# Verilator flow for the multi-cycle CPU

VERILATOR  ?= verilator
FILELIST   ?= cpu.f
TB_TOP     ?= cpu_tb
RTL_TOP    ?= cpu_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/cpu_tb.sv
`default_nettype none
`include "cpu_params.svh"

module cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_PROGS  = 3;
   localparam int MAX_WORDS  = 32;
   localparam int MAX_CHECKS = 8;

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   start;
   logic                   running;
   logic                   halted;
   logic [`CPU_XLEN-1:0]   pc_value;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`CPU_APB_AW-1:0] paddr;
   logic [`CPU_XLEN-1:0]   pwdata;
   logic [`CPU_XLEN-1:0]   prdata;
   logic                   pready;
   logic                   pslverr;

   // One row per program: image, instructions executed, expected memory words
   logic [`CPU_XLEN-1:0] prog_words [NUM_PROGS][MAX_WORDS];
   int                   prog_len   [NUM_PROGS] = '{default: 0};
   int                   exp_instrs [NUM_PROGS];
   int                   exp_addr   [NUM_PROGS][MAX_CHECKS];
   logic [`CPU_XLEN-1:0] exp_data   [NUM_PROGS][MAX_CHECKS];
   int                   exp_count  [NUM_PROGS] = '{default: 0};
   int                   cycle_count   = 0;
   int                   timeout_limit = 0;

   cpu_top cpu_top_i (
      .clk(clk), .rst(rst), .start(start), .running(running), .halted(halted),
      .pc_value(pc_value), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   always #50 clk = ~clk;

   // Armed once the table is built
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit > 0 && cycle_count > timeout_limit) begin
         $display("Test failed");
         $fatal(1, "Timeout, the run did not end within %0d cycles", timeout_limit);
      end
   end

   function automatic logic [`CPU_XLEN-1:0] encode_instr(input cpu_pkg::instr_type_t op,
         input int rd, input int ra, input int rb, input logic [15:0] low);
      logic [`CPU_XLEN-1:0] w;
      w = {op, 5'(rd), 5'(ra), 5'(rb), 12'h000};
      w[15:0] = w[15:0] | low;
      return w;
   endfunction

   function automatic logic [`CPU_XLEN-1:0] alu_expect(input cpu_pkg::alu_op_t op,
         input logic [`CPU_XLEN-1:0] x, input logic [`CPU_XLEN-1:0] y);
      case (op)
         cpu_pkg::ALU_ADD: return x + y;
         cpu_pkg::ALU_SUB: return x - y;
         cpu_pkg::ALU_AND: return x & y;
         cpu_pkg::ALU_OR:  return x | y;
         cpu_pkg::ALU_XOR: return x ^ y;
         cpu_pkg::ALU_SHL: return x << y[4:0];
         cpu_pkg::ALU_SHR: return x >> y[4:0];
         default:          return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      endcase
   endfunction

   task automatic emit(input int p, input logic [`CPU_XLEN-1:0] w);
      prog_words[p][prog_len[p]] = w;
      prog_len[p] = prog_len[p] + 1;
   endtask

   task automatic expect_mem(input int p, input int addr, input logic [`CPU_XLEN-1:0] value);
      exp_addr[p][exp_count[p]] = addr;
      exp_data[p][exp_count[p]] = value;
      exp_count[p] = exp_count[p] + 1;
   endtask

   task automatic check_word(input string name, input logic [`CPU_XLEN-1:0] got,
         input logic [`CPU_XLEN-1:0] want);
      if (got !== want) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, want);
         $display("Test failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // Setup phase, access phase, then idle
   task automatic apb_transfer(input logic write, input int word_addr,
         input logic [`CPU_XLEN-1:0] wdata, output logic [`CPU_XLEN-1:0] rdata,
         output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = `CPU_APB_AW'(word_addr * 4);
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      rdata = prdata;
      err   = pslverr;
      check_bit("pready", pready, 1'b1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic start_run(output int c0);
      @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      c0 = cycle_count;
      check_bit("running", running, 1'b1);
      check_bit("halted", halted, 1'b0);
      check_word("pc_value", pc_value, '0);
   endtask

   // Five cycles per executed instruction, counted from the start edge
   task automatic finish_run(input int c0, input int instrs);
      while (!halted) begin
         @(negedge clk);
      end
      check_word("run_cycles", cycle_count - c0, 5 * instrs);
      check_bit("running", running, 1'b0);
   endtask

   task automatic check_results(input int p);
      logic [`CPU_XLEN-1:0] rdata;
      logic                 err;
      for (int i = 0; i < exp_count[p]; i++) begin
         apb_transfer(1'b0, exp_addr[p][i], '0, rdata, err);
         check_bit("pslverr", err, 1'b0);
         check_word($sformatf("mem[0x%0h]", exp_addr[p][i]), rdata, exp_data[p][i]);
      end
   endtask

   task automatic build_table();
      logic [`CPU_XLEN-1:0] a;
      logic [`CPU_XLEN-1:0] b;
      logic [`CPU_XLEN-1:0] x;
      logic [`CPU_XLEN-1:0] src [3];
      cpu_pkg::alu_op_t     op;
      int                   ra_r;
      int                   n;
      // ALU program, r1 = -a and r2 = b, results at 0x40 upward
      a = $urandom & 32'h0000_ffff;
      b = $urandom & 32'h0000_ffff;
      x = -a;
      emit(0, encode_instr(cpu_pkg::INSTR_LOADI, 1, 0, 0, a[15:0]));
      emit(0, encode_instr(cpu_pkg::INSTR_LOADI, 2, 0, 0, b[15:0]));
      emit(0, encode_instr(cpu_pkg::INSTR_ALU, 1, 0, 1, 16'(cpu_pkg::ALU_SUB)));
      for (int k = 0; k < 8; k++) begin
         op = cpu_pkg::alu_op_t'(k);
         emit(0, encode_instr(cpu_pkg::INSTR_ALU, 3 + k, 1, 2, 16'(op)));
         emit(0, encode_instr(cpu_pkg::INSTR_LOADI, 12, 0, 0, 16'('h40 + k)));
         emit(0, encode_instr(cpu_pkg::INSTR_STORE, 3 + k, 12, 0, 16'h0));
         expect_mem(0, 'h40 + k, alu_expect(op, x, b));
      end
      emit(0, encode_instr(cpu_pkg::INSTR_HALT, 0, 0, 0, 16'h0));
      exp_instrs[0] = prog_len[0];

      // Copies words 20..22 to 0x50 upward, then the r0 cases
      for (int i = 0; i < 3; i++) begin
         src[i] = $urandom;
         // Third copy loads over its own address register
         ra_r = (i == 2) ? 4 : 1;
         emit(1, encode_instr(cpu_pkg::INSTR_LOADI, ra_r, 0, 0, 16'(20 + i)));
         emit(1, encode_instr(cpu_pkg::INSTR_LOAD, 2 + i, ra_r, 0, 16'h0));
         emit(1, encode_instr(cpu_pkg::INSTR_LOADI, 6, 0, 0, 16'('h50 + i)));
         emit(1, encode_instr(cpu_pkg::INSTR_STORE, 2 + i, 6, 0, 16'h0));
         expect_mem(1, 'h50 + i, src[i]);
      end
      emit(1, encode_instr(cpu_pkg::INSTR_LOADI, 0, 0, 0, 16'h1234));
      emit(1, encode_instr(cpu_pkg::INSTR_LOAD, 0, 1, 0, 16'h0));
      emit(1, encode_instr(cpu_pkg::INSTR_LOADI, 6, 0, 0, 16'h0053));
      emit(1, encode_instr(cpu_pkg::INSTR_STORE, 0, 6, 0, 16'h0));
      expect_mem(1, 'h53, '0);
      emit(1, encode_instr(cpu_pkg::INSTR_HALT, 0, 0, 0, 16'h0));
      exp_instrs[1] = prog_len[1];
      for (int i = prog_len[1]; i < 20; i++) begin
         emit(1, '0);
      end
      for (int i = 0; i < 3; i++) begin
         emit(1, src[i]);
      end

      // Countdown from n, loop body at word 4, pass count stored at 0x60
      n = 3 + ($urandom % 6);
      emit(2, encode_instr(cpu_pkg::INSTR_LOADI, 1, 0, 0, 16'(n)));
      emit(2, encode_instr(cpu_pkg::INSTR_LOADI, 2, 0, 0, 16'h0001));
      emit(2, encode_instr(cpu_pkg::INSTR_LOADI, 3, 0, 0, 16'h0000));
      emit(2, encode_instr(cpu_pkg::INSTR_LOADI, 4, 0, 0, 16'h0004));
      emit(2, encode_instr(cpu_pkg::INSTR_ALU, 3, 3, 2, 16'(cpu_pkg::ALU_ADD)));
      emit(2, encode_instr(cpu_pkg::INSTR_ALU, 1, 1, 2, 16'(cpu_pkg::ALU_SUB)));
      emit(2, encode_instr(cpu_pkg::INSTR_JNZ, 1, 4, 0, 16'h0));
      emit(2, encode_instr(cpu_pkg::INSTR_LOADI, 5, 0, 0, 16'h0060));
      emit(2, encode_instr(cpu_pkg::INSTR_STORE, 3, 5, 0, 16'h0));
      emit(2, encode_instr(cpu_pkg::INSTR_HALT, 0, 0, 0, 16'h0));
      exp_instrs[2] = 4 + 3 * n + 3;
      expect_mem(2, 'h60, n);
   endtask

   initial begin
      logic [`CPU_XLEN-1:0] rdata;
      logic                 err;
      int                   c0;
      int                   limit;

      void'($urandom(79));
      rst     = 1'b0;
      start   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_table();

      // Runs, three cycles per APB transfer, the second countdown run and slack
      limit = 100 + 5 * exp_instrs[2] + 30;
      for (int p = 0; p < NUM_PROGS; p++) begin
         limit = limit + 5 * exp_instrs[p] + 3 * (prog_len[p] + exp_count[p]) + 10;
      end
      timeout_limit = limit;

      repeat (10) @(negedge clk);
      rst = 1'b1;
      @(negedge clk);
      check_bit("running", running, 1'b0);
      check_bit("halted", halted, 1'b0);
      check_bit("pslverr", pslverr, 1'b0);
      check_word("pc_value", pc_value, '0);

      for (int p = 0; p < NUM_PROGS; p++) begin
         for (int i = 0; i < prog_len[p]; i++) begin
            apb_transfer(1'b1, i, prog_words[p][i], rdata, err);
            check_bit("pslverr", err, 1'b0);
         end
         start_run(c0);
         finish_run(c0, exp_instrs[p]);
         check_results(p);
      end

      // Countdown again after clearing its result, APB refused meanwhile
      apb_transfer(1'b1, 'h60, '1, rdata, err);
      check_bit("pslverr", err, 1'b0);
      apb_transfer(1'b0, 'h60, '0, rdata, err);
      check_word("mem[0x60]", rdata, '1);
      start_run(c0);
      apb_transfer(1'b1, 'h40, 32'h5a5a_0f0f, rdata, err);
      check_bit("pslverr", err, 1'b1);
      apb_transfer(1'b0, 'h40, '0, rdata, err);
      check_bit("pslverr", err, 1'b1);
      check_word("prdata", rdata, '0);
      finish_run(c0, exp_instrs[2]);
      check_results(2);
      check_results(0);

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`default_nettype none
`include "cpu_params.svh"

module cpu_top (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   start,
   output logic                        running,
   output logic                        halted,
   output logic [`CPU_XLEN-1:0]        pc_value,
   input  wire logic                   psel,
   input  wire logic                   penable,
   input  wire logic                   pwrite,
   input  wire logic [`CPU_APB_AW-1:0] paddr,
   input  wire logic [`CPU_XLEN-1:0]   pwdata,
   output logic [`CPU_XLEN-1:0]        prdata,
   output logic                        pready,
   output logic                        pslverr
);

   cpu_pkg::stage_t              stage;
   cpu_pkg::alu_op_t             alu_op;
   logic [`CPU_XLEN-1:0]         mem_rdata;
   logic [`CPU_XLEN-1:0]         mem_addr;
   logic [`CPU_XLEN-1:0]         mem_wdata;
   logic                         mem_wen;
   logic [`CPU_XLEN-1:0]         rdata_0;
   logic [`CPU_XLEN-1:0]         rdata_1;
   logic [$clog2(`CPU_REGS)-1:0] reg_raddr_0;
   logic [$clog2(`CPU_REGS)-1:0] reg_raddr_1;
   logic [$clog2(`CPU_REGS)-1:0] reg_waddr;
   logic [`CPU_XLEN-1:0]         reg_wdata;
   logic                         reg_wen;
   logic [`CPU_XLEN-1:0]         alu_in_0;
   logic [`CPU_XLEN-1:0]         alu_in_1;
   logic [`CPU_XLEN-1:0]         alu_result;

   stage_counter #(.N(`CPU_NUM_STAGES)) stage_counter_i (
      .clk(clk), .rst(rst), .run(running), .stage(stage)
   );

   cpu_control cpu_control_i (
      .clk(clk), .rst(rst), .start(start), .stage(stage),
      .mem_rdata(mem_rdata), .rdata_0(rdata_0), .rdata_1(rdata_1),
      .alu_result(alu_result), .running(running), .halted(halted),
      .pc_value(pc_value), .reg_raddr_0(reg_raddr_0), .reg_raddr_1(reg_raddr_1),
      .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .reg_wen(reg_wen),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wen(mem_wen),
      .alu_in_0(alu_in_0), .alu_in_1(alu_in_1), .alu_op(alu_op)
   );

   alu alu_i (
      .in_0(alu_in_0), .in_1(alu_in_1), .op(alu_op), .result(alu_result)
   );

   register_file register_file_i (
      .clk(clk), .rst(rst), .raddr_0(reg_raddr_0), .raddr_1(reg_raddr_1),
      .waddr(reg_waddr), .wdata(reg_wdata), .wen(reg_wen),
      .rdata_0(rdata_0), .rdata_1(rdata_1)
   );

   main_memory main_memory_i (
      .clk(clk), .rst(rst), .running(running), .addr(mem_addr),
      .wdata(mem_wdata), .wen(mem_wen), .rdata(mem_rdata),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

endmodule

`default_nettype wire

// File: design/main_memory.sv
`default_nettype none
`include "cpu_params.svh"

module main_memory (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   running,
   input  wire logic [`CPU_XLEN-1:0]   addr,
   input  wire logic [`CPU_XLEN-1:0]   wdata,
   input  wire logic                   wen,
   output logic [`CPU_XLEN-1:0]        rdata,
   input  wire logic                   psel,
   input  wire logic                   penable,
   input  wire logic                   pwrite,
   input  wire logic [`CPU_APB_AW-1:0] paddr,
   input  wire logic [`CPU_XLEN-1:0]   pwdata,
   output logic [`CPU_XLEN-1:0]        prdata,
   output logic                        pready,
   output logic                        pslverr
);

   localparam int AW = $clog2(`CPU_MEM_DEPTH);

   logic [`CPU_XLEN-1:0] mem [`CPU_MEM_DEPTH];
   logic [AW-1:0]        cpu_index;
   logic [AW-1:0]        apb_index;
   logic                 apb_setup;
   logic                 apb_access;

   // Addresses wrap modulo the depth
   assign cpu_index  = addr[AW-1:0];
   assign apb_index  = paddr[AW+1:2];
   assign apb_setup  = psel && !penable;
   assign apb_access = psel && penable;

   assign rdata   = mem[cpu_index];
   assign pready  = 1'b1;
   assign pslverr = apb_access && running;

   // Processor writes only while running, APB only while stopped
   always_ff @(posedge clk) begin
      if (wen) begin
         mem[cpu_index] <= wdata;
      end else if (apb_access && pwrite && !running) begin
         mem[apb_index] <= pwdata;
      end
   end

   // Read data captured in setup so it is stable for the whole access phase
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         prdata <= '0;
      end else if (apb_setup && !pwrite) begin
         if (running) begin
            prdata <= '0;
         end else begin
            prdata <= mem[apb_index];
         end
      end
   end

endmodule

`default_nettype wire

// File: design/register_file.sv
`default_nettype none
`include "cpu_params.svh"

module register_file (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic [$clog2(`CPU_REGS)-1:0] raddr_0,
   input  wire logic [$clog2(`CPU_REGS)-1:0] raddr_1,
   input  wire logic [$clog2(`CPU_REGS)-1:0] waddr,
   input  wire logic [`CPU_XLEN-1:0]         wdata,
   input  wire logic                         wen,
   output logic [`CPU_XLEN-1:0]              rdata_0,
   output logic [`CPU_XLEN-1:0]              rdata_1
);

   logic [`CPU_XLEN-1:0] regs [`CPU_REGS];

   // Writes to r0 are dropped
   always_ff @(posedge clk) begin
      if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // Registered read ports, r0 reads as zero
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         rdata_0 <= '0;
         rdata_1 <= '0;
      end else begin
         if (raddr_0 == '0) begin
            rdata_0 <= '0;
         end else begin
            rdata_0 <= regs[raddr_0];
         end
         if (raddr_1 == '0) begin
            rdata_1 <= '0;
         end else begin
            rdata_1 <= regs[raddr_1];
         end
      end
   end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none
`include "cpu_params.svh"

module alu (
   input  wire logic [`CPU_XLEN-1:0] in_0,
   input  wire logic [`CPU_XLEN-1:0] in_1,
   input  wire cpu_pkg::alu_op_t     op,
   output logic [`CPU_XLEN-1:0]      result
);

   logic [4:0] shamt;
   logic       less;

   // Shift amount from the low five bits only
   assign shamt = in_1[4:0];
   assign less  = $signed(in_0) < $signed(in_1);

   always_comb begin
      case (op)
         cpu_pkg::ALU_ADD: begin
            result = in_0 + in_1;
         end
         cpu_pkg::ALU_SUB: begin
            result = in_0 - in_1;
         end
         cpu_pkg::ALU_AND: begin
            result = in_0 & in_1;
         end
         cpu_pkg::ALU_OR: begin
            result = in_0 | in_1;
         end
         cpu_pkg::ALU_XOR: begin
            result = in_0 ^ in_1;
         end
         cpu_pkg::ALU_SHL: begin
            result = in_0 << shamt;
         end
         cpu_pkg::ALU_SHR: begin
            result = in_0 >> shamt;
         end
         cpu_pkg::ALU_SLT: begin
            result = {{(`CPU_XLEN-1){1'b0}}, less};
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: design/cpu_control.sv
`default_nettype none
`include "cpu_params.svh"

module cpu_control (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         start,
   input  wire cpu_pkg::stage_t              stage,
   input  wire logic [`CPU_XLEN-1:0]         mem_rdata,
   input  wire logic [`CPU_XLEN-1:0]         rdata_0,
   input  wire logic [`CPU_XLEN-1:0]         rdata_1,
   input  wire logic [`CPU_XLEN-1:0]         alu_result,
   output logic                              running,
   output logic                              halted,
   output logic [`CPU_XLEN-1:0]              pc_value,
   output logic [$clog2(`CPU_REGS)-1:0]      reg_raddr_0,
   output logic [$clog2(`CPU_REGS)-1:0]      reg_raddr_1,
   output logic [$clog2(`CPU_REGS)-1:0]      reg_waddr,
   output logic [`CPU_XLEN-1:0]              reg_wdata,
   output logic                              reg_wen,
   output logic [`CPU_XLEN-1:0]              mem_addr,
   output logic [`CPU_XLEN-1:0]              mem_wdata,
   output logic                              mem_wen,
   output logic [`CPU_XLEN-1:0]              alu_in_0,
   output logic [`CPU_XLEN-1:0]              alu_in_1,
   output cpu_pkg::alu_op_t                  alu_op
);

   logic [`CPU_XLEN-1:0]         pc;
   logic [`CPU_XLEN-1:0]         pc_next;
   logic [`CPU_XLEN-1:0]         issue_reg;
   logic [`CPU_XLEN-1:0]         imm;
   logic [$clog2(`CPU_REGS)-1:0] rd;
   logic [$clog2(`CPU_REGS)-1:0] ra;
   logic [$clog2(`CPU_REGS)-1:0] rb;
   cpu_pkg::instr_type_t         itype;
   logic                         writes_reg;

   // Instruction fields
   assign itype = cpu_pkg::instr_type_t'(issue_reg[31:27]);
   assign rd    = issue_reg[26:22];
   assign ra    = issue_reg[21:17];
   assign rb    = issue_reg[16:12];
   assign imm   = {16'h0000, issue_reg[15:0]};

   assign pc_value = pc;

   // Idle, running and halted held in two flags
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         running <= 1'b0;
         halted  <= 1'b0;
         pc      <= '0;
      end else if (!running) begin
         if (start) begin
            running <= 1'b1;
            halted  <= 1'b0;
            pc      <= '0;
         end
      end else if (stage == cpu_pkg::STAGE_PC_UPDATE) begin
         if (itype == cpu_pkg::INSTR_HALT) begin
            running <= 1'b0;
            halted  <= 1'b1;
         end else begin
            pc <= pc_next;
         end
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         issue_reg <= '0;
      end else if (running && stage == cpu_pkg::STAGE_FETCH) begin
         issue_reg <= mem_rdata;
      end
   end

   // Port 1 carries rb for ALU ops and rd otherwise (store data, jump test)
   assign reg_raddr_0 = ra;
   assign reg_raddr_1 = (itype == cpu_pkg::INSTR_ALU) ? rb : rd;

   // Jump target in ra, condition in rd
   assign pc_next = (itype == cpu_pkg::INSTR_JNZ && rdata_1 != '0) ? rdata_0 : pc + 1'b1;

   assign alu_in_0 = rdata_0;
   assign alu_in_1 = rdata_1;
   assign alu_op   = cpu_pkg::alu_op_t'(issue_reg[3:0]);

   // Fetch uses the PC, later stages address through ra
   assign mem_addr  = (stage == cpu_pkg::STAGE_FETCH) ? pc : rdata_0;
   assign mem_wdata = rdata_1;
   assign mem_wen   = running && stage == cpu_pkg::STAGE_EXECUTE &&
                      itype == cpu_pkg::INSTR_STORE;

   always_comb begin
      case (itype)
         cpu_pkg::INSTR_LOADI: begin
            writes_reg = 1'b1;
            reg_wdata  = imm;
         end
         cpu_pkg::INSTR_LOAD: begin
            writes_reg = 1'b1;
            reg_wdata  = mem_rdata;
         end
         cpu_pkg::INSTR_ALU: begin
            writes_reg = 1'b1;
            reg_wdata  = alu_result;
         end
         default: begin
            writes_reg = 1'b0;
            reg_wdata  = alu_result;
         end
      endcase
   end

   assign reg_waddr = rd;
   assign reg_wen   = running && stage == cpu_pkg::STAGE_WRITEBACK && writes_reg;

endmodule

`default_nettype wire

// File: design/stage_counter.sv
`default_nettype none
`include "cpu_params.svh"

module stage_counter #(
   parameter int N = `CPU_NUM_STAGES
) (
   input  wire logic     clk,
   input  wire logic     rst,
   input  wire logic     run,
   output cpu_pkg::stage_t stage
);

   logic last_stage;

   assign last_stage = (stage == cpu_pkg::stage_t'(N - 1));

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         stage <= cpu_pkg::STAGE_FETCH;
      end else if (!run) begin
         // Parked so that a new run starts with a fetch
         stage <= cpu_pkg::STAGE_FETCH;
      end else if (last_stage) begin
         stage <= cpu_pkg::STAGE_FETCH;
      end else begin
         stage <= cpu_pkg::stage_t'(stage + 3'd1);
      end
   end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   // Opcode in instruction bits 31..27, other codes do nothing
   typedef enum logic [4:0] {
      INSTR_LOADI = 5'd1,
      INSTR_LOAD  = 5'd2,
      INSTR_STORE = 5'd3,
      INSTR_ALU   = 5'd4,
      INSTR_JNZ   = 5'd5,
      INSTR_HALT  = 5'd6
   } instr_type_t;

   // ALU operation in instruction bits 3..0
   typedef enum logic [3:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SHL = 4'd5,
      ALU_SHR = 4'd6,
      ALU_SLT = 4'd7
   } alu_op_t;

   // One cycle per stage, in this order
   typedef enum logic [2:0] {
      STAGE_FETCH     = 3'd0,
      STAGE_DECODE    = 3'd1,
      STAGE_EXECUTE   = 3'd2,
      STAGE_WRITEBACK = 3'd3,
      STAGE_PC_UPDATE = 3'd4
   } stage_t;

endpackage

`default_nettype wire

// File: design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data, instruction and address width
`define CPU_XLEN 32

// Register file size
`define CPU_REGS 32

// Unified memory size in words
`define CPU_MEM_DEPTH 256

// APB byte address width, word index sits in bits 9..2
`define CPU_APB_AW 10

// Stages per instruction
`define CPU_NUM_STAGES 5

`endif
